//--- build.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_load_align.sv
hw/dcache_tag_stage.sv
hw/dcache_miss_stage.sv
hw/dcache_resp_buf.sv
hw/dcache_read_top.sv
dv/dcache_mem_model.sv
dv/tb_dcache_read.sv

//--- dv/tb_dcache_read.sv
// testbench for the load-only data cache read unit
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module tb_dcache_read import dcache_pkg::*; ();

  localparam int MAX_CYCLES = 4000;

  typedef struct packed {
    word_t  rdata;
    rid_t   rid;
    paddr_t paddr;
    logic   ale;
  } exp_t;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic flush_i = 1'b0;
  logic req_valid_i = 1'b0;
  logic req_ready_o;
  load_req_t req_i = '0;
  sram_idx_t sram_idx;
  cache_tag_t [`DC_WAYS-1:0] sram_tag;
  word_t [`DC_WAYS-1:0] sram_data;
  refill_req_t refill_req;
  refill_resp_t refill_resp;
  logic lsu_resp_valid_o;
  logic lsu_resp_ready_i = 1'b1;
  load_resp_t lsu_resp_o;

  exp_t exp_q[$];
  exp_t exp_head = '0;
  int exp_cnt = 0;
  int errors = 0;
  int cycles = 0;
  int accept_cnt = 0;
  int refills = 0;
  int tests = 0;
  rid_t next_rid = '0;
  logic bus_allowed = 1'b0;
  logic rand_ready = 1'b0;
  paddr_t exp_refill_addr = '0;
  msize_t exp_refill_size = 2'd2;
  string test_name = "reset";

  dcache_read_top i_dcache_read_top (
    .clk, .rst_n, .flush_i, .req_valid_i, .req_ready_o, .req_i,
    .sram_idx_o (sram_idx), .sram_tag_i (sram_tag), .sram_data_i (sram_data),
    .refill_req_o (refill_req), .refill_resp_i (refill_resp),
    .lsu_resp_valid_o, .lsu_resp_ready_i, .lsu_resp_o
  );

  dcache_mem_model i_mem (
    .clk, .sram_idx_i (sram_idx), .sram_tag_o (sram_tag), .sram_data_o (sram_data),
    .refill_req_i (refill_req), .refill_resp_o (refill_resp)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  // word a load should see from the hit way or else the backing memory
  function automatic word_t lookup_word(paddr_t a);
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (i_mem.tag_mem[a[11:4]][w].rp && i_mem.tag_mem[a[11:4]][w].ppn == a[31:12]) begin
        return i_mem.data_mem[a[11:4]][w];
      end
    end
    return {a[31:2], 2'b00} * 32'h9e37_79b1;
  endfunction

  function automatic exp_t expect_resp(load_req_t r);
    exp_t  e;
    word_t w;
    logic [7:0]  b;
    logic [15:0] h;
    w = lookup_word(r.paddr);
    b = w[r.paddr[1:0]*8 +: 8];
    h = w[r.paddr[1]*16 +: 16];
    e.rid = r.rid;
    e.paddr = r.paddr;
    e.ale = (r.msize == 2'd1 && r.paddr[0]) || (r.msize == 2'd2 && r.paddr[1:0] != 0);
    case (r.msize)
      2'd0: e.rdata = r.msigned ? {{24{b[7]}}, b} : {24'h0, b};
      2'd1: e.rdata = r.msigned ? {{16{h[15]}}, h} : {16'h0, h};
      default: e.rdata = w;
    endcase
    if (e.ale) begin
      e.rdata = '0;
    end
    return e;
  endfunction

  function automatic paddr_t present_addr(int idx, int way, logic [3:0] off);
    return {i_mem.tag_mem[idx][way].ppn, idx[7:0], off};
  endfunction

  function automatic paddr_t absent_addr(int idx, logic [3:0] off);
    return {i_mem.tag_mem[idx][0].ppn ^ 20'h80000, idx[7:0], off};
  endfunction

  // scoreboard queue pops on a taken response and pushes on an accepted request
  always @(posedge clk) begin
    cycles++;
    if (rst_n && lsu_resp_valid_o && lsu_resp_ready_i && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
    if (rst_n && flush_i) begin
      exp_q.delete();
    end else if (rst_n && req_valid_i && req_ready_o) begin
      exp_q.push_back(expect_resp(req_i));
      accept_cnt <= accept_cnt + 1;
    end
    if (refill_req.valid && refill_resp.ready) begin
      refills++;
    end
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles in test %s", cycles, test_name);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  always @(negedge clk) begin
    exp_cnt  = exp_q.size();
    exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
    if (rand_ready) begin
      lsu_resp_ready_i = $urandom() % 2;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
      (lsu_resp_valid_o && lsu_resp_ready_i) |-> exp_cnt != 0)
    else begin
      errors++;
      $display("response rid %h came out with no load outstanding in test %s",
               $sampled(lsu_resp_o.rid), test_name);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
      (lsu_resp_valid_o && lsu_resp_ready_i && exp_cnt != 0) |->
      (lsu_resp_o.rdata == exp_head.rdata && lsu_resp_o.rid == exp_head.rid &&
       lsu_resp_o.paddr == exp_head.paddr && lsu_resp_o.ale == exp_head.ale))
    else begin
      errors++;
      $display("[FAIL] %s rdata/rid/paddr/ale expected %h/%h/%h/%b actual %h/%h/%h/%b",
               test_name, $sampled(exp_head.rdata), $sampled(exp_head.rid),
               $sampled(exp_head.paddr), $sampled(exp_head.ale),
               $sampled(lsu_resp_o.rdata), $sampled(lsu_resp_o.rid),
               $sampled(lsu_resp_o.paddr), $sampled(lsu_resp_o.ale));
    end

  assert property (@(posedge clk) disable iff (!rst_n || flush_i)
      (lsu_resp_valid_o && !lsu_resp_ready_i) |=> (lsu_resp_valid_o && $stable(lsu_resp_o)))
    else begin
      errors++;
      $display("held response changed or vanished in test %s", test_name);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
      refill_req.valid |-> (bus_allowed && refill_req.paddr == exp_refill_addr &&
                            refill_req.msize == exp_refill_size))
    else begin
      errors++;
      $display("[FAIL] %s refill paddr/msize expected %h/%0d actual %h/%0d (bus allowed %b)",
               test_name, $sampled(exp_refill_addr), $sampled(exp_refill_size),
               $sampled(refill_req.paddr), $sampled(refill_req.msize),
               $sampled(bus_allowed));
    end

  // called at a falling edge and returns at the falling edge after acceptance
  task automatic issue_load(paddr_t a, msize_t sz, logic sgn);
    int n;
    n = accept_cnt;
    req_valid_i = 1'b1;
    req_i = '{paddr: a, msize: sz, msigned: sgn, rid: next_rid};
    next_rid++;
    while (accept_cnt == n) begin
      @(negedge clk);
    end
  endtask

  task automatic idle(int n);
    req_valid_i = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    req_valid_i = 1'b0;
    while ((exp_q.size() != 0 || lsu_resp_valid_o) && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (waited >= 200) begin
      errors++;
      $display("test %s lost %0d responses", test_name, exp_q.size());
    end
  endtask

  task automatic finish_test(int errs_before);
    tests++;
    $display("test %-12s %s", test_name, (errors == errs_before) ? "ok" : "errors");
  endtask

  initial begin
    int e0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_name = "reset_word";
    e0 = errors;
    assert (req_ready_o && !lsu_resp_valid_o && !refill_req.valid)
      else begin
        errors++;
        $display("[FAIL] %s ready/resp valid/refill valid expected 1/0/0 actual %b/%b/%b",
                 test_name, req_ready_o, lsu_resp_valid_o, refill_req.valid);
      end
    issue_load(present_addr(5, 2, 4'h8), 2'd2, 1'b0);
    wait_drain();
    finish_test(e0);

    test_name = "byte_half";
    e0 = errors;
    for (int s = 0; s < 2; s++) begin
      for (int o = 0; o < 4; o++) begin
        issue_load(present_addr(17 + o, o, o[3:0]), 2'd0, s[0]);
      end
      issue_load(present_addr(40, 1, 4'h0), 2'd1, s[0]);
      issue_load(present_addr(41, 3, 4'h6), 2'd1, s[0]);
    end
    wait_drain();
    finish_test(e0);

    test_name = "miss_refill";
    e0 = errors;
    exp_refill_addr = absent_addr(99, 4'h4);
    exp_refill_size = 2'd2;
    bus_allowed = 1'b1;
    issue_load(exp_refill_addr, exp_refill_size, 1'b0);
    wait_drain();
    bus_allowed = 1'b0;
    assert (refills == 1)
      else begin
        errors++;
        $display("[FAIL] %s bus refills expected 1 actual %0d", test_name, refills);
      end
    issue_load(exp_refill_addr, exp_refill_size, 1'b0);
    wait_drain();
    finish_test(e0);

    test_name = "backpressure";
    e0 = errors;
    rand_ready = 1'b1;
    for (int i = 0; i < 40; i++) begin
      issue_load(present_addr($urandom() % 256, $urandom() % 4, $urandom() % 16),
                 $urandom() % 3, $urandom() % 2);
    end
    wait_drain();
    rand_ready = 1'b0;
    lsu_resp_ready_i = 1'b1;
    finish_test(e0);

    test_name = "misaligned";
    e0 = errors;
    issue_load(absent_addr(7, 4'h1), 2'd1, 1'b1);
    issue_load(absent_addr(8, 4'h3), 2'd1, 1'b0);
    for (int o = 1; o < 4; o++) begin
      issue_load(absent_addr(9 + o, o[3:0]), 2'd2, 1'b0);
    end
    wait_drain();
    finish_test(e0);

    test_name = "flush";
    e0 = errors;
    lsu_resp_ready_i = 1'b0;
    for (int i = 0; i < 3; i++) begin
      issue_load(present_addr(60 + i, i, 4'h0), 2'd2, 1'b0);
    end
    idle(3);
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    lsu_resp_ready_i = 1'b1;
    issue_load(present_addr(70, 3, 4'h2), 2'd1, 1'b1);
    issue_load(present_addr(71, 0, 4'hc), 2'd0, 1'b0);
    wait_drain();
    finish_test(e0);

    idle(4);
    $display("tests %0d, check failures %0d, cycles %0d", tests, errors, cycles);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/dcache_mem_model.sv
// tag/data sram and refill bus model for the data cache read unit testbench
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module dcache_mem_model import dcache_pkg::*; (
  input  wire logic         clk,
  input  wire sram_idx_t    sram_idx_i,
  output cache_tag_t [`DC_WAYS-1:0] sram_tag_o,
  output word_t [`DC_WAYS-1:0]      sram_data_o,
  input  wire refill_req_t  refill_req_i,
  output refill_resp_t      refill_resp_o = '0
);

  localparam int REFILL_DELAY = 4;   // cycles before the bus answers

  cache_tag_t  tag_mem [256][`DC_WAYS];
  word_t       data_mem [256][`DC_WAYS];
  int unsigned wait_cnt = 0;
  int unsigned rnd;

  // word the backing memory holds at an address
  function automatic word_t backing_word(paddr_t a);
    return {a[31:2], 2'b00} * 32'h9e37_79b1;
  endfunction

  initial begin
    rnd = $urandom(48);
    for (int i = 0; i < 256; i++) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        rnd = $urandom();
        tag_mem[i][w].ppn = {rnd[17:0], w[1:0]};   // low bits keep ways distinct
        tag_mem[i][w].rp  = 1'b1;
        data_mem[i][w]    = $urandom();
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      sram_tag_o[w]  <= tag_mem[sram_idx_i][w];
      sram_data_o[w] <= data_mem[sram_idx_i][w];
    end
  end

  always @(posedge clk) begin
    refill_resp_o.ready <= 1'b0;
    if (refill_req_i.valid && !refill_resp_o.ready) begin
      if (wait_cnt == REFILL_DELAY - 1) begin
        wait_cnt <= 0;
        refill_resp_o.ready <= 1'b1;
        refill_resp_o.rdata <= backing_word(refill_req_i.paddr);
        // install the line in way 0
        tag_mem[refill_req_i.paddr[11:4]][0]  <= '{ppn: refill_req_i.paddr[31:12], rp: 1'b1};
        data_mem[refill_req_i.paddr[11:4]][0] <= backing_word(refill_req_i.paddr);
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/dcache_read_top.sv
// load-only data cache read unit, two pipeline stages and a response buffer
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module dcache_read_top import dcache_pkg::*; (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      flush_i,
  input  wire logic                      req_valid_i,
  output logic                           req_ready_o,
  input  wire load_req_t                 req_i,
  output sram_idx_t                      sram_idx_o,
  input  wire cache_tag_t [`DC_WAYS-1:0] sram_tag_i,
  input  wire word_t [`DC_WAYS-1:0]      sram_data_i,
  output refill_req_t                    refill_req_o,
  input  wire refill_resp_t              refill_resp_i,
  output logic                           lsu_resp_valid_o,
  input  wire logic                      lsu_resp_ready_i,
  output load_resp_t                     lsu_resp_o
);

  logic       stall;
  logic       m1_valid;
  m2_pack_t   m1_pack;
  logic       resp_valid;
  load_resp_t resp;
  logic       buf_ready;

  assign req_ready_o = !stall;
  assign sram_idx_o  = req_i.paddr[`DC_IDX_W+3:4];   // line index

  dcache_tag_stage i_tag_stage (
    .clk, .rst_n, .flush_i,
    .req_valid_i, .req_i,
    .stall_i     (stall),
    .sram_tag_i, .sram_data_i,
    .m1_valid_o  (m1_valid),
    .m1_pack_o   (m1_pack)
  );

  dcache_miss_stage i_miss_stage (
    .clk, .rst_n, .flush_i,
    .m1_valid_i   (m1_valid),
    .m1_pack_i    (m1_pack),
    .buf_ready_i  (buf_ready),
    .refill_resp_i,
    .stall_o      (stall),
    .refill_req_o,
    .resp_valid_o (resp_valid),
    .resp_o       (resp)
  );

  dcache_resp_buf i_resp_buf (
    .clk, .rst_n, .flush_i,
    .valid_i (resp_valid),
    .resp_i  (resp),
    .ready_i (lsu_resp_ready_i),
    .ready_o (buf_ready),
    .valid_o (lsu_resp_valid_o),
    .resp_o  (lsu_resp_o)
  );

endmodule

`default_nettype wire

//--- hw/dcache_resp_buf.sv
// one-entry response buffer between the miss stage and the consumer
`timescale 1ns/1ps
`default_nettype none

module dcache_resp_buf import dcache_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       flush_i,
  input  wire logic       valid_i,
  input  wire load_resp_t resp_i,
  input  wire logic       ready_i,
  output logic            ready_o,
  output logic            valid_o,
  output load_resp_t      resp_o
);

  logic       valid_q;
  load_resp_t resp_q;

  // free when empty or drained this cycle
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ready_o) begin
      resp_q <= resp_i;
    end
  end

  assign valid_o = valid_q;
  assign resp_o  = resp_q;      // held while the consumer stalls

endmodule

`default_nettype wire

//--- hw/dcache_miss_stage.sv
// M2 stage, returns the hit word or refills a missing word over the bus
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module dcache_miss_stage import dcache_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         flush_i,
  input  wire logic         m1_valid_i,
  input  wire m2_pack_t     m1_pack_i,
  input  wire logic         buf_ready_i,
  input  wire refill_resp_t refill_resp_i,
  output logic              stall_o,
  output refill_req_t       refill_req_o,
  output logic              resp_valid_o,
  output load_resp_t        resp_o
);

  logic     m2_valid_q;
  m2_pack_t m2_q;
  fsm_e     fsm_q;
  fsm_e     fsm_d;
  mode_e    mode_q;
  mode_e    mode_d;
  word_t    refill_word_q;
  word_t    hit_word;
  word_t    raw_word;
  word_t    aligned_word;
  logic     refill_done;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      m2_valid_q <= 1'b0;
    end else if (!stall_o) begin
      m2_valid_q <= m1_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_o) begin
      m2_q <= m1_pack_i;
    end
  end

  // flush leaves a running refill alone, the bus must see it finish
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fsm_q <= S_NORMAL;
    end else begin
      fsm_q <= fsm_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      mode_q <= M_NORMAL;
    end else begin
      mode_q <= mode_d;
    end
  end

  assign refill_done = (fsm_q == S_REFILL) && refill_resp_i.ready;

  always_ff @(posedge clk) begin
    if (refill_done) begin
      refill_word_q <= refill_resp_i.rdata;
    end
  end

  // at most one way hits
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (m2_q.hit[w]) begin
        hit_word = hit_word | m2_q.data[w];
      end
    end
  end

  assign raw_word = (mode_q == M_HANDLED) ? refill_word_q : hit_word;

  dcache_load_align i_load_align (
    .word_i    (raw_word),
    .offset_i  (m2_q.req.paddr[1:0]),
    .msize_i   (m2_q.req.msize),
    .msigned_i (m2_q.req.msigned),
    .word_o    (aligned_word)
  );

  always_comb begin
    resp_o.rdata = m2_q.ale ? '0 : aligned_word;
    resp_o.rid   = m2_q.req.rid;
    resp_o.paddr = m2_q.req.paddr;
    resp_o.ale   = m2_q.ale;
  end

  always_comb begin
    refill_req_o.valid = (fsm_q == S_REFILL);
    refill_req_o.paddr = m2_q.req.paddr;      // m2 is frozen during the refill
    refill_req_o.msize = m2_q.req.msize;
  end

  always_comb begin
    fsm_d        = fsm_q;
    mode_d       = mode_q;
    stall_o      = 1'b1;
    resp_valid_o = 1'b0;
    case (fsm_q)
      S_REFILL: begin
        if (refill_resp_i.ready) begin
          fsm_d  = S_NORMAL;
          mode_d = M_HANDLED;
        end
      end
      default: begin
        if (mode_q == M_HANDLED) begin
          // refilled word waits here for the buffer
          resp_valid_o = m2_valid_q;
          if (buf_ready_i || !m2_valid_q) begin
            stall_o = 1'b0;
            mode_d  = M_NORMAL;
          end
        end else if (m2_valid_q && !m2_q.any_hit && !m2_q.ale) begin
          fsm_d = S_REFILL;
        end else begin
          resp_valid_o = m2_valid_q;
          stall_o      = m2_valid_q && !buf_ready_i;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/dcache_tag_stage.sv
// M1 stage, registers the load and computes way hits and misalignment
`timescale 1ns/1ps
`default_nettype none
`include "dcache_cfg.svh"

module dcache_tag_stage import dcache_pkg::*; (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      flush_i,
  input  wire logic                      req_valid_i,
  input  wire load_req_t                 req_i,
  input  wire logic                      stall_i,
  input  wire cache_tag_t [`DC_WAYS-1:0] sram_tag_i,
  input  wire word_t [`DC_WAYS-1:0]      sram_data_i,
  output logic                           m1_valid_o,
  output m2_pack_t                       m1_pack_o
);

  logic                      m1_valid_q;
  load_req_t                 req_q;
  logic                      stall_q;
  cache_tag_t [`DC_WAYS-1:0] tag_q;
  cache_tag_t [`DC_WAYS-1:0] tag_sel;
  word_t [`DC_WAYS-1:0]      data_q;
  word_t [`DC_WAYS-1:0]      data_sel;
  logic [`DC_WAYS-1:0]       way_hit;
  logic                      ale;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      m1_valid_q <= 1'b0;
    end else if (!stall_i) begin
      m1_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      req_q <= req_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= stall_i;
    end
  end

  // sram output is only good for one cycle, so keep a copy while stalled
  assign tag_sel  = stall_q ? tag_q : sram_tag_i;
  assign data_sel = stall_q ? data_q : sram_data_i;

  always_ff @(posedge clk) begin
    tag_q  <= tag_sel;
    data_q <= data_sel;
  end

  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      way_hit[w] = tag_sel[w].rp &&
                   (tag_sel[w].ppn == req_q.paddr[`DC_ADDR_W-1 -: `DC_TAG_W]);
    end
  end

  // bytes are never misaligned
  always_comb begin
    case (req_q.msize)
      2'd0:    ale = 1'b0;
      2'd1:    ale = req_q.paddr[0];
      default: ale = |req_q.paddr[1:0];
    endcase
  end

  assign m1_valid_o        = m1_valid_q;
  assign m1_pack_o.req     = req_q;
  assign m1_pack_o.hit     = way_hit;
  assign m1_pack_o.any_hit = |way_hit;
  assign m1_pack_o.ale     = ale;
  assign m1_pack_o.data    = data_sel;

endmodule

`default_nettype wire

//--- hw/dcache_load_align.sv
// load data alignment, shifts by byte offset and extends by size and sign
`timescale 1ns/1ps
`default_nettype none

module dcache_load_align import dcache_pkg::*; (
  input  wire word_t  word_i,
  input  wire logic [1:0] offset_i,
  input  wire msize_t msize_i,
  input  wire logic   msigned_i,
  output word_t       word_o
);

  word_t shifted;
  logic  byte_sign;
  logic  half_sign;

  assign shifted = word_i >> {offset_i, 3'b000};

  // sign bit of the accessed field, zero for unsigned loads
  assign byte_sign = msigned_i & shifted[7];
  assign half_sign = msigned_i & shifted[15];

  always_comb begin
    case (msize_i)
      2'd0: begin
        word_o = {{24{byte_sign}}, shifted[7:0]};
      end
      2'd1: begin
        word_o = {{16{half_sign}}, shifted[15:0]};
      end
      default: begin
        word_o = shifted;      // full word, nothing to extend
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/dcache_pkg.sv
// types shared by the data cache read unit stages
`default_nettype none
`include "dcache_cfg.svh"

package dcache_pkg;

  typedef logic [`DC_ADDR_W-1:0] paddr_t;
  typedef logic [`DC_WORD_W-1:0] word_t;
  typedef logic [`DC_IDX_W-1:0]  sram_idx_t;
  typedef logic [`DC_RID_W-1:0]  rid_t;
  typedef logic [1:0]            msize_t;   // 0 byte, 1 half, 2 word

  typedef struct packed {
    logic [`DC_TAG_W-1:0] ppn;
    logic                 rp;               // line readable
  } cache_tag_t;

  typedef struct packed {
    paddr_t paddr;
    msize_t msize;
    logic   msigned;
    rid_t   rid;
  } load_req_t;

  // M1 results handed to M2
  typedef struct packed {
    load_req_t                 req;
    logic [`DC_WAYS-1:0]       hit;
    logic                      any_hit;
    logic                      ale;
    word_t [`DC_WAYS-1:0]      data;
  } m2_pack_t;

  typedef struct packed {
    word_t  rdata;
    rid_t   rid;
    paddr_t paddr;
    logic   ale;
  } load_resp_t;

  typedef struct packed {
    logic   valid;
    paddr_t paddr;
    msize_t msize;
  } refill_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } refill_resp_t;

  typedef enum logic {S_NORMAL, S_REFILL} fsm_e;
  typedef enum logic {M_NORMAL, M_HANDLED} mode_e;

endpackage

`default_nettype wire

//--- hw/dcache_cfg.svh
// data cache read unit geometry and field widths
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// set associativity
`define DC_WAYS   4

// address and data path
`define DC_ADDR_W 32
`define DC_WORD_W 32

// index is addr[11:4], tag is addr[31:12]
`define DC_IDX_W  8
`define DC_TAG_W  20

`define DC_RID_W  6   // writeback id of a load

`endif
